// ==== Makefile ====
TOP = decodeStageTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module decodeStage
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
verilog/decodePkg.sv
verilog/instrCapture.sv
verilog/controlDecode.sv
verilog/immGen.sv
verilog/regScoreboard.sv
verilog/decodeStage.sv
sim/decodeStageTb.sv

// ==== sim/decodeStageTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeStageTb import decodePkg::*; ();

    localparam int maxCycles = 2000; // watchdog limit in clock periods

    logic clk;
    logic reset;
    logic block;
    logic validIn;
    xlenWord_t pcIn;
    instrWord_t instrRead;
    logic instrError;
    logic csrError;
    logic jmp;
    logic wbValid;
    regIdx_t wbRd;
    wire issueValid;
    wire rsBlock;
    xlenWord_t pc;
    immWord_t imm;
    regIdx_t rd;
    logic [11:0] csrAddr;
    aluCtrl_t aluCtrl;
    wire aluASrc;
    wire [1:0] aluBSrc;
    branchKind_t branch;
    wire memRd;
    wire memWr;
    wire [2:0] memOp;
    wire regWr;
    wire csrOp;
    wire ecall;
    wire mret;
    wire ebreak;
    wire illegal;

    integer seed;
    integer testErrors;
    integer passCount;
    integer failCount;

    // reference model results
    immWord_t expImm;
    aluCtrl_t expAluCtrl;
    branchKind_t expBranch;
    logic expMemRd;
    logic expMemWr;
    logic expRegWr;
    logic expASrc;
    logic [1:0] expBSrc;

    decodeStage uut (
        .clk(clk), .reset(reset), .block(block), .validIn(validIn), .pcIn(pcIn),
        .instrRead(instrRead), .instrError(instrError), .csrError(csrError), .jmp(jmp),
        .wbValid(wbValid), .wbRd(wbRd), .issueValid(issueValid), .rsBlock(rsBlock),
        .pc(pc), .imm(imm), .rd(rd), .csrAddr(csrAddr), .aluCtrl(aluCtrl),
        .aluASrc(aluASrc), .aluBSrc(aluBSrc), .branch(branch), .memRd(memRd),
        .memWr(memWr), .memOp(memOp), .regWr(regWr), .csrOp(csrOp), .ecall(ecall),
        .mret(mret), .ebreak(ebreak), .illegal(illegal)
    );

    always #4 clk = ~clk;

    initial begin
        #(maxCycles * 8);
        $display("watchdog expired before the tests completed");
        $display("Testbench failed");
        $finish;
    end

    function automatic instrWord_t rType(input logic [6:0] f7, input regIdx_t rs2,
                                         input regIdx_t rs1, input logic [2:0] f3,
                                         input regIdx_t rdIdx, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rdIdx, op};
    endfunction

    function automatic instrWord_t iType(input logic [11:0] imm12, input regIdx_t rs1,
                                         input logic [2:0] f3, input regIdx_t rdIdx,
                                         input logic [6:0] op);
        return {imm12, rs1, f3, rdIdx, op};
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            testErrors++;
        end
    endtask

    // controls and immediate from the encoding rules
    task automatic predict(input instrWord_t w);
        logic [6:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [3:0] aluOp;
        op = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        aluOp = 4'd0;
        if (op == opOp || op == opOp32) aluOp = {f7[5], f3};
        else if (op == opOpImm || op == opOpImm32) aluOp = {f7[5] & (f3 == 3'd5), f3};
        else if (op == opBranch) aluOp = f3[1] ? 4'd3 : 4'd2;
        else if (op == opLui || op == opSystem) aluOp = 4'd15;
        expAluCtrl = {(op == opOp || op == opOp32) & f7[0], op[3] & ~op[2], aluOp};
        expBranch = 3'd0;
        if (op == opJal) expBranch = 3'd1;
        else if (op == opJalr) expBranch = 3'd2;
        else if (op == opBranch) expBranch = (f3 == 3'd0) ? 3'd4 : (f3 == 3'd1) ? 3'd5 :
                                             f3[0] ? 3'd7 : 3'd6;
        expMemRd = (op == opLoad);
        expMemWr = (op == opStore);
        expRegWr = !(op == opStore || op == opBranch);
        expASrc = (op == opAuipc || op == opJal || op == opJalr);
        if (op == opJal || op == opJalr) expBSrc = 2'd1;
        else if (op == opSystem) expBSrc = 2'd3;
        else if (op == opOp || op == opOp32 || op == opBranch) expBSrc = 2'd0;
        else expBSrc = 2'd2;
        if (op == opStore || op == opOp || op == opOp32)
            expImm = 32'($signed({w[31:25], w[11:7]}));
        else if (op == opBranch)
            expImm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        else if (op == opLui || op == opAuipc)
            expImm = {w[31:12], 12'h000};
        else if (op == opJal)
            expImm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        else
            expImm = 32'($signed(w[31:20]));
    endtask

    task automatic checkDecode(input instrWord_t w);
        predict(w);
        checkValue("imm", imm, expImm);
        checkValue("aluCtrl", aluCtrl, expAluCtrl);
        checkValue("branch", branch, expBranch);
        checkValue("memRd", memRd, expMemRd);
        checkValue("memWr", memWr, expMemWr);
        checkValue("regWr", regWr, expRegWr);
        checkValue("aluASrc", aluASrc, expASrc);
        checkValue("aluBSrc", aluBSrc, expBSrc);
        checkValue("rd", rd, w[11:7]);
        checkValue("csrAddr", csrAddr, w[31:20]);
        checkValue("csrOp", csrOp, w[6:0] == opSystem);
        checkValue("illegal", illegal, 1'b0);
        if (expMemRd || expMemWr) checkValue("memOp", memOp, w[14:12]);
    endtask

    task automatic resetDut();
        @(negedge clk);
        reset = 1'b1;
        validIn = 1'b1; // a live slot that only reset keeps empty
        block = 1'b0;
        jmp = 1'b0;
        wbValid = 1'b0;
        csrError = 1'b0;
        instrError = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        validIn = 1'b0;
    endtask

    // pc in one cycle, word the next, then settle before the rising edge
    task automatic loadSlot(input xlenWord_t pcVal, input instrWord_t w, input logic err,
                            input logic csrErr);
        @(negedge clk);
        validIn = 1'b1;
        pcIn = pcVal;
        @(negedge clk);
        validIn = 1'b0;
        instrRead = w;
        instrError = err;
        csrError = csrErr;
        #2;
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic expectIllegal(input instrWord_t w, input logic err, input logic csrErr,
                                 input logic exp);
        loadSlot(64'h300, w, err, csrErr);
        checkValue("illegal", illegal, exp);
    endtask

    initial begin
        instrWord_t w;
        instrWord_t ctrlCases[$];
        logic [6:0] immOps[5];
        seed = 44421;
        testErrors = 0;
        passCount = 0;
        failCount = 0;
        clk = 1'b0;
        reset = 1'b1;
        block = 1'b0;
        validIn = 1'b0;
        pcIn = '0;
        instrRead = '0;
        instrError = 1'b0;
        csrError = 1'b0;
        jmp = 1'b0;
        wbValid = 1'b0;
        wbRd = '0;

        resetDut();
        #2;
        checkValue("issueValid", issueValid, 1'b0);
        checkValue("rsBlock", rsBlock, 1'b0);
        w = iType(12'h010, 5'd1, 3'd0, 5'd2, opOpImm);
        loadSlot(64'h1000, w, 1'b0, 1'b0);
        checkValue("issueValid", issueValid, 1'b1);
        checkValue("pc", pc, 64'h1000);
        checkDecode(w);
        finishTest("reset");

        immOps = '{opOpImm, opStore, opBranch, opLui, opJal};
        foreach (immOps[i]) begin
            repeat (16) begin
                w = $random(seed);
                w[6:0] = immOps[i];
                loadSlot(64'h40, w, 1'b0, 1'b0);
                predict(w);
                checkValue("imm", imm, expImm);
            end
        end
        finishTest("immediates");

        ctrlCases.push_back(rType(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, opOp)); // add
        ctrlCases.push_back(rType(7'h20, 5'd3, 5'd2, 3'd0, 5'd1, opOp)); // sub
        ctrlCases.push_back(rType(7'h01, 5'd3, 5'd2, 3'd0, 5'd1, opOp32)); // mulw
        ctrlCases.push_back(iType(12'h005, 5'd2, 3'd0, 5'd1, opOpImm));
        ctrlCases.push_back(iType(12'h403, 5'd2, 3'd5, 5'd1, opOpImm)); // srai
        ctrlCases.push_back(iType(12'hff0, 5'd2, 3'd2, 5'd1, opLoad)); // lw
        ctrlCases.push_back(rType(7'h01, 5'd3, 5'd2, 3'd3, 5'd4, opStore)); // sd
        ctrlCases.push_back(rType(7'h00, 5'd3, 5'd2, 3'd0, 5'd8, opBranch)); // beq
        ctrlCases.push_back(rType(7'h7f, 5'd3, 5'd2, 3'd6, 5'd9, opBranch)); // bltu
        ctrlCases.push_back({20'h12345, 5'd1, opJal});
        ctrlCases.push_back(iType(12'h008, 5'd2, 3'd0, 5'd1, opJalr));
        ctrlCases.push_back({20'hfedcb, 5'd1, opLui});
        ctrlCases.push_back({20'h00042, 5'd1, opAuipc});
        ctrlCases.push_back(iType(12'h340, 5'd2, 3'd1, 5'd1, opSystem)); // csrrw
        foreach (ctrlCases[i]) begin
            loadSlot(64'h200 + 4 * i, ctrlCases[i], 1'b0, 1'b0);
            checkDecode(ctrlCases[i]);
        end
        finishTest("control");

        repeat (10) begin
            w = $random(seed);
            if (w[1:0] == 2'b11) w[1:0] = 2'b01;
            expectIllegal(w, 1'b0, 1'b0, 1'b1);
        end
        expectIllegal(rType(7'h02, 5'd3, 5'd2, 3'd0, 5'd1, opOp), 1'b0, 1'b0, 1'b1);
        expectIllegal(rType(7'h00, 5'd3, 5'd2, 3'd2, 5'd1, opBranch), 1'b0, 1'b0, 1'b1);
        expectIllegal(iType(12'h000, 5'd2, 3'd7, 5'd1, opLoad), 1'b0, 1'b0, 1'b1);
        expectIllegal(iType(12'h000, 5'd2, 3'd1, 5'd1, opJalr), 1'b0, 1'b0, 1'b1);
        expectIllegal(ctrlCases[0], 1'b1, 1'b0, 1'b1); // fetch fault on add
        expectIllegal(32'h1050_0073, 1'b0, 1'b0, 1'b1); // wfi not supported
        expectIllegal(ctrlCases[13], 1'b0, 1'b1, 1'b1);
        expectIllegal(ctrlCases[13], 1'b0, 1'b0, 1'b0);
        expectIllegal(instrEcall, 1'b0, 1'b0, 1'b0);
        checkValue("ecall", {ecall, mret, ebreak}, 3'b100);
        expectIllegal(instrMret, 1'b0, 1'b0, 1'b0);
        checkValue("mret", {ecall, mret, ebreak}, 3'b010);
        expectIllegal(instrEbreak, 1'b0, 1'b0, 1'b0);
        checkValue("ebreak", {ecall, mret, ebreak}, 3'b001);
        finishTest("illegal");

        resetDut();
        w = iType(12'hff0, 5'd3, 3'd2, 5'd9, opLoad);
        @(negedge clk);
        validIn = 1'b1;
        pcIn = 64'h2000;
        @(negedge clk);
        validIn = 1'b0;
        instrRead = w;
        block = 1'b1;
        #2;
        checkDecode(w);
        repeat (4) begin
            @(negedge clk);
            instrRead = $random(seed);
            pcIn = {$random(seed), $random(seed)};
            validIn = 1'b1;
            #2;
            checkDecode(w);
            checkValue("pc", pc, 64'h2000);
            checkValue("issueValid", issueValid, 1'b1);
        end
        @(negedge clk);
        block = 1'b0;
        validIn = 1'b0;
        instrRead = $random(seed);
        #2;
        checkDecode(w); // held word still in decode this cycle
        checkValue("pc", pc, 64'h2000);
        w = rType(7'h20, 5'd13, 5'd12, 3'd0, 5'd11, opOp);
        loadSlot(64'h2004, w, 1'b0, 1'b0);
        checkDecode(w);
        checkValue("pc", pc, 64'h2004);
        checkValue("issueValid", issueValid, 1'b1);
        finishTest("stall");

        resetDut();
        @(negedge clk);
        validIn = 1'b1;
        pcIn = 64'h100;
        @(negedge clk);
        instrRead = iType(12'h001, 5'd0, 3'd0, 5'd5, opOpImm); // writes x5
        pcIn = 64'h104;
        #2;
        checkValue("issueValid", issueValid, 1'b1);
        @(negedge clk);
        validIn = 1'b0;
        instrRead = rType(7'h00, 5'd0, 5'd5, 3'd0, 5'd6, opOp); // reads x5
        block = 1'b1;
        #2;
        checkValue("rsBlock", rsBlock, 1'b1);
        checkValue("issueValid", issueValid, 1'b0);
        @(negedge clk);
        instrRead = $random(seed);
        #2;
        checkValue("rsBlock", rsBlock, 1'b1);
        checkValue("issueValid", issueValid, 1'b0);
        @(negedge clk);
        jmp = 1'b1;
        #2;
        checkValue("rsBlock", rsBlock, 1'b0);
        checkValue("issueValid", issueValid, 1'b0);
        @(negedge clk);
        jmp = 1'b0;
        wbValid = 1'b1;
        wbRd = 5'd5;
        #2;
        checkValue("rsBlock", rsBlock, 1'b0);
        checkValue("issueValid", issueValid, 1'b1);
        @(negedge clk);
        wbValid = 1'b0;
        block = 1'b0;
        @(negedge clk);
        validIn = 1'b1;
        pcIn = 64'h200;
        @(negedge clk);
        instrRead = iType(12'h001, 5'd0, 3'd0, 5'd0, opOpImm); // writes x0
        pcIn = 64'h204;
        #2;
        checkValue("issueValid", issueValid, 1'b1);
        @(negedge clk);
        validIn = 1'b0;
        instrRead = rType(7'h00, 5'd0, 5'd0, 3'd0, 5'd7, opOp);
        #2;
        checkValue("rsBlock", rsBlock, 1'b0);
        checkValue("issueValid", issueValid, 1'b1);
        finishTest("scoreboard");

        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/controlDecode.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlDecode import decodePkg::*; (
    input  wire instrWord_t instr,
    input  wire             fetchError,
    input  wire             csrError,
    output immFormat_t      fmt,
    output aluCtrl_t        aluCtrl,
    output logic            aluASrc,
    output logic [1:0]      aluBSrc,
    output branchKind_t     branch,
    output logic            memRd,
    output logic            memWr,
    output logic [2:0]      memOp,
    output logic            regWr,
    output logic            csrOp,
    output logic            ecall,
    output logic            mret,
    output logic            ebreak,
    output logic            usesRs1,
    output logic            usesRs2,
    output logic            illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [3:0] aluOp;
    logic badFunct;
    logic mulDiv;
    logic wordOp;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        fmt = fmtI;
        aluOp = aluOpNone;
        aluBSrc = bSrcRs2;
        branch = brNone;
        badFunct = 1'b0;
        case (opcode)
            opLoad: begin
                aluBSrc = bSrcImm;
                badFunct = (funct3 == 3'b111); // no ldu
            end
            opStore: begin
                fmt = fmtS;
                aluBSrc = bSrcImm;
                badFunct = funct3[2];
            end
            opOpImm: begin
                aluBSrc = bSrcImm;
                aluOp = {funct7[5] && (funct3 == 3'b101), funct3};
                // rv64 shifts take a 6-bit shamt, funct6 only
                badFunct = ((funct3 == 3'b001) && (funct7[6:1] != 6'b000000)) ||
                           ((funct3 == 3'b101) && (funct7[6:1] != 6'b000000) &&
                            (funct7[6:1] != 6'b010000));
            end
            opOpImm32: begin
                aluBSrc = bSrcImm;
                aluOp = {funct7[5] && (funct3 == 3'b101), funct3};
                badFunct = !((funct3 == 3'b000) ||
                             ((funct3 == 3'b001) && (funct7 == 7'b0000000)) ||
                             ((funct3 == 3'b101) && ((funct7 == 7'b0000000) ||
                                                     (funct7 == 7'b0100000))));
            end
            opOp: begin
                fmt = fmtS;
                aluOp = {funct7[5], funct3};
                badFunct = !((funct7 == 7'b0000000) || (funct7 == 7'b0000001) ||
                             ((funct7 == 7'b0100000) &&
                              ((funct3 == 3'b000) || (funct3 == 3'b101))));
            end
            opOp32: begin
                fmt = fmtS;
                aluOp = {funct7[5], funct3};
                case (funct7)
                    7'b0000000: badFunct = !((funct3 == 3'b000) || (funct3 == 3'b001) ||
                                             (funct3 == 3'b101));
                    7'b0100000: badFunct = !((funct3 == 3'b000) || (funct3 == 3'b101));
                    7'b0000001: badFunct = (funct3 == 3'b001) || (funct3 == 3'b010) ||
                                           (funct3 == 3'b011); // no mulhw variants
                    default: badFunct = 1'b1;
                endcase
            end
            opLui: begin
                fmt = fmtU;
                aluBSrc = bSrcImm;
                aluOp = aluOpPass;
            end
            opAuipc: begin
                fmt = fmtU;
                aluBSrc = bSrcImm;
            end
            opJal: begin
                fmt = fmtJ;
                aluBSrc = bSrcFour; // link value is pc+4
                branch = brJal;
            end
            opJalr: begin
                aluBSrc = bSrcFour;
                branch = brJalr;
                badFunct = (funct3 != 3'b000);
            end
            opBranch: begin
                fmt = fmtB;
                aluOp = funct3[1] ? aluOpCmpU : aluOpCmpS;
                branch = {1'b1, funct3[2], funct3[0]}; // beq..bgeu fold to 4..7
                badFunct = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            opSystem: begin
                aluBSrc = bSrcCsr;
                aluOp = aluOpPass;
                if (funct3 == 3'b000) begin
                    badFunct = (instr != instrEcall) && (instr != instrEbreak) &&
                               (instr != instrMret);
                end else begin
                    badFunct = (funct3 == 3'b100) || csrError;
                end
            end
            default: badFunct = 1'b1;
        endcase
    end

    assign mulDiv = ((opcode == opOp) || (opcode == opOp32)) && funct7[0];
    assign wordOp = opcode[3] && !opcode[2];
    assign aluCtrl = {mulDiv, wordOp, aluOp};

    assign aluASrc = (opcode == opAuipc) || (opcode == opJal) || (opcode == opJalr);
    assign memRd = (opcode == opLoad);
    assign memWr = (opcode == opStore);
    assign memOp = funct3;
    assign regWr = (opcode != opStore) && (opcode != opBranch);
    assign csrOp = (opcode == opSystem);

    assign ecall = (instr == instrEcall);
    assign ebreak = (instr == instrEbreak);
    assign mret = (instr == instrMret);

    assign usesRs1 = (fmt == fmtI) || (fmt == fmtS) || (fmt == fmtB);
    assign usesRs2 = (fmt == fmtS) || (fmt == fmtB);

    assign illegal = badFunct || (opcode[1:0] != 2'b11) || fetchError;

endmodule

`default_nettype wire

// ==== verilog/decodePkg.sv ====
`default_nettype none

package decodePkg;

    localparam int xlen = 64;
    localparam int instrWidth = 32;
    localparam int regIdxWidth = 5;
    localparam int regCount = 1 << regIdxWidth;
    localparam int immWidth = 32;
    localparam int aluCtrlWidth = 6;
    localparam int branchWidth = 3;

    typedef logic [xlen-1:0] xlenWord_t;
    typedef logic [instrWidth-1:0] instrWord_t;
    typedef logic [regIdxWidth-1:0] regIdx_t;
    typedef logic [immWidth-1:0] immWord_t; // sign-extended to xlen in execute
    typedef logic [aluCtrlWidth-1:0] aluCtrl_t;
    typedef logic [branchWidth-1:0] branchKind_t;

    // R type shares the S encoding for source use
    typedef enum logic [2:0] {
        fmtI = 3'd0,
        fmtJ = 3'd1,
        fmtS = 3'd2,
        fmtB = 3'd3,
        fmtU = 3'd5
    } immFormat_t;

    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opOpImm32 = 7'b0011011;
    localparam logic [6:0] opOp = 7'b0110011;
    localparam logic [6:0] opOp32 = 7'b0111011;
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;
    localparam logic [6:0] opJal = 7'b1101111;
    localparam logic [6:0] opJalr = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opSystem = 7'b1110011;

    // alu b operand select
    localparam logic [1:0] bSrcRs2 = 2'd0;
    localparam logic [1:0] bSrcFour = 2'd1;
    localparam logic [1:0] bSrcImm = 2'd2;
    localparam logic [1:0] bSrcCsr = 2'd3;

    localparam logic [3:0] aluOpNone = 4'd0;
    localparam logic [3:0] aluOpCmpS = 4'd2;
    localparam logic [3:0] aluOpCmpU = 4'd3;
    localparam logic [3:0] aluOpPass = 4'd15; // lui and csr group

    localparam branchKind_t brNone = 3'd0;
    localparam branchKind_t brJal = 3'd1;
    localparam branchKind_t brJalr = 3'd2;

    localparam instrWord_t instrEcall = 32'h0000_0073;
    localparam instrWord_t instrEbreak = 32'h0010_0073;
    localparam instrWord_t instrMret = 32'h3020_0073;

endpackage

`default_nettype wire

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeStage import decodePkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             block,
    input  wire             validIn,
    input  wire xlenWord_t  pcIn,
    input  wire instrWord_t instrRead,
    input  wire             instrError,
    input  wire             csrError,
    input  wire             jmp,
    input  wire             wbValid,
    input  wire regIdx_t    wbRd,
    output wire             issueValid,
    output wire             rsBlock,
    output xlenWord_t       pc,
    output immWord_t        imm,
    output regIdx_t         rd,
    output logic [11:0]     csrAddr,
    output aluCtrl_t        aluCtrl,
    output wire             aluASrc,
    output wire [1:0]       aluBSrc,
    output branchKind_t     branch,
    output wire             memRd,
    output wire             memWr,
    output wire [2:0]       memOp,
    output wire             regWr,
    output wire             csrOp,
    output wire             ecall,
    output wire             mret,
    output wire             ebreak,
    output wire             illegal
);

    logic slotValid;
    instrWord_t instr;
    logic fetchError;
    immFormat_t fmt;
    logic usesRs1;
    logic usesRs2;
    regIdx_t rs1;
    regIdx_t rs2;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd = instr[11:7];
    assign csrAddr = instr[31:20];

    instrCapture capture (
        .clk(clk), .reset(reset), .block(block), .validIn(validIn), .pcIn(pcIn),
        .instrRead(instrRead), .instrError(instrError), .slotValid(slotValid),
        .pc(pc), .instr(instr), .fetchError(fetchError)
    );

    controlDecode decode (
        .instr(instr), .fetchError(fetchError), .csrError(csrError), .fmt(fmt),
        .aluCtrl(aluCtrl), .aluASrc(aluASrc), .aluBSrc(aluBSrc), .branch(branch),
        .memRd(memRd), .memWr(memWr), .memOp(memOp), .regWr(regWr), .csrOp(csrOp),
        .ecall(ecall), .mret(mret), .ebreak(ebreak), .usesRs1(usesRs1),
        .usesRs2(usesRs2), .illegal(illegal)
    );

    immGen immediate (
        .instr(instr), .fmt(fmt), .imm(imm)
    );

    regScoreboard scoreboard (
        .clk(clk), .reset(reset), .block(block), .jmp(jmp), .slotValid(slotValid),
        .rs1(rs1), .rs2(rs2), .rd(rd), .usesRs1(usesRs1), .usesRs2(usesRs2),
        .regWr(regWr), .wbValid(wbValid), .wbRd(wbRd), .rsBlock(rsBlock),
        .issueValid(issueValid)
    );

endmodule

`default_nettype wire

// ==== verilog/immGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module immGen import decodePkg::*; (
    input  wire instrWord_t instr,
    input  wire immFormat_t fmt,
    output immWord_t        imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (fmt)
            fmtS: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            fmtB: begin
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            fmtU: imm = {instr[31:12], 12'b0};
            fmtJ: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm = {{20{sign}}, instr[31:20]}; // I type
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/instrCapture.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrCapture import decodePkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             block,
    input  wire             validIn,
    input  wire xlenWord_t  pcIn,
    input  wire instrWord_t instrRead,
    input  wire             instrError,
    output logic            slotValid,
    output xlenWord_t       pc,
    output instrWord_t      instr,
    output logic            fetchError
);

    logic blockQ;
    instrWord_t heldInstr;
    logic heldError;

    always_ff @(posedge clk) begin
        if (reset) begin
            slotValid <= 1'b0;
            blockQ <= 1'b0;
        end else begin
            blockQ <= block;
            if (!block) begin
                slotValid <= validIn;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            pc <= pcIn;
        end
    end

    // keep whatever decode is looking at, so a stall replays it
    always_ff @(posedge clk) begin
        heldInstr <= instr;
        heldError <= fetchError;
    end

    // memory word is only live in the first cycle of a slot
    assign instr = blockQ ? heldInstr : instrRead;
    assign fetchError = blockQ ? heldError : instrError;

endmodule

`default_nettype wire

// ==== verilog/regScoreboard.sv ====
`timescale 1ns/1ns
`default_nettype none

module regScoreboard import decodePkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire          block,
    input  wire          jmp,
    input  wire          slotValid,
    input  wire regIdx_t rs1,
    input  wire regIdx_t rs2,
    input  wire regIdx_t rd,
    input  wire          usesRs1,
    input  wire          usesRs2,
    input  wire          regWr,
    input  wire          wbValid,
    input  wire regIdx_t wbRd,
    output logic         rsBlock,
    output logic         issueValid
);

    logic [regCount-1:0] busy;
    logic rs1Busy;
    logic rs2Busy;

    // writeback in this cycle already frees the register
    assign rs1Busy = busy[rs1] && !(wbValid && (wbRd == rs1)) && (rs1 != '0);
    assign rs2Busy = busy[rs2] && !(wbValid && (wbRd == rs2)) && (rs2 != '0);

    assign rsBlock = slotValid && !jmp && ((usesRs1 && rs1Busy) || (usesRs2 && rs2Busy));
    assign issueValid = slotValid && !rsBlock && !jmp;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (wbValid) begin
                busy[wbRd] <= 1'b0;
            end
            // later assignment wins, so a new producer beats the clear
            if (issueValid && !block && regWr && (rd != '0)) begin
                busy[rd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
